// File: pwo_engine.f
src/pwo_params_pkg.sv
src/pwo_types_pkg.sv
src/coef_mem_if.sv
src/coef_ram.sv
src/pwo_sequencer.sv
src/pwo_lane_alu.sv
src/pwo_writeback.sv
src/pwo_top.sv
tests/pwo_checker.sv
tests/pwo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the engine testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f pwo_engine.f --top-module pwo_tb -o pwo_sim > build.log 2>&1 \
    && ./obj_dir/pwo_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^Finished with no errors$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: src/coef_mem_if.sv
// Coefficient memory port

interface coef_mem_if #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) ();

    // Write side
    logic                                     we;
    logic [ADDR_W-1:0]                        waddr;
    logic [LANES*pwo_params_pkg::COEF_W-1:0]  wdata;

    // Read side, data one cycle after re
    logic                                     re;
    logic [ADDR_W-1:0]                        raddr;
    logic [LANES*pwo_params_pkg::COEF_W-1:0]  rdata;

    modport ram (
        input  we, waddr, wdata, re, raddr,
        output rdata
    );

    modport reader (
        output re, raddr,
        input  rdata
    );

    modport writer (
        output we, waddr, wdata
    );

endinterface : coef_mem_if

// File: src/coef_ram.sv
// Coefficient word memory

module coef_ram #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            zeroize_i,
    coef_mem_if.ram         mem_port_i
);

    localparam int DEPTH  = 2 ** ADDR_W;
    localparam int WORD_W = LANES * pwo_params_pkg::COEF_W;

    logic [WORD_W-1:0] mem [DEPTH];

    // Zeroize wins over a host or engine write
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_port_i.we) begin
            mem[mem_port_i.waddr] <= mem_port_i.wdata;
        end
    end

    // Registered read, holds the last word between strobes
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_port_i.rdata <= '0;
        end else if (mem_port_i.re) begin
            mem_port_i.rdata <= mem[mem_port_i.raddr];
        end
    end

endmodule : coef_ram

// File: src/pwo_lane_alu.sv
// Pointwise lane ALU

module pwo_lane_alu #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) (
    input  logic                                     clk,
    input  logic                                     arst_n_i,
    input  pwo_types_pkg::pwo_mode_e                 mode_i,
    input  logic                                     in_valid_i,
    input  logic [ADDR_W-1:0]                        in_addr_i,
    input  logic [LANES*pwo_params_pkg::COEF_W-1:0]  opa_i,
    input  logic [LANES*pwo_params_pkg::COEF_W-1:0]  opb_i,
    output logic                                     res_valid_o,
    output logic [ADDR_W-1:0]                        res_addr_o,
    output logic [LANES*pwo_params_pkg::COEF_W-1:0]  res_o
);

    localparam int CW = pwo_params_pkg::COEF_W;
    localparam int PW = pwo_params_pkg::PROD_W;
    localparam logic [PW-1:0] Q_EXT = PW'(pwo_params_pkg::MOD_Q);

    logic                      s1_valid;
    logic [ADDR_W-1:0]         s1_addr;
    pwo_types_pkg::pwo_mode_e  s1_mode;  // Mode of the word in stage 1

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid    <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            s1_valid    <= in_valid_i;
            res_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr    <= in_addr_i;
        s1_mode    <= mode_i;
        res_addr_o <= s1_addr;
    end

    for (genvar ln = 0; ln < LANES; ln++) begin : g_lane
        logic [CW-1:0] a;
        logic [CW-1:0] b;
        logic [PW-1:0] raw_d;
        logic [PW-1:0] raw_q;
        logic [CW-1:0] red;
        logic [CW-1:0] res_q;

        assign a = opa_i[ln*CW +: CW];
        assign b = opb_i[ln*CW +: CW];

        // Stage 1, raw result; a negative difference wraps with MSB set
        always_comb begin
            case (mode_i)
                pwo_types_pkg::MODE_PWM: raw_d = PW'(a) * PW'(b);
                pwo_types_pkg::MODE_PWA: raw_d = PW'(a) + PW'(b);
                pwo_types_pkg::MODE_PWS: raw_d = PW'(a) - PW'(b);
                default:                 raw_d = '0;
            endcase
        end

        // Stage 2, reduce into 0 .. q-1
        always_comb begin
            case (s1_mode)
                pwo_types_pkg::MODE_PWM: red = CW'(raw_q % Q_EXT);
                pwo_types_pkg::MODE_PWA: red = (raw_q >= Q_EXT) ? CW'(raw_q - Q_EXT) : CW'(raw_q);
                pwo_types_pkg::MODE_PWS: red = raw_q[PW-1] ? CW'(raw_q + Q_EXT) : CW'(raw_q);
                default:                 red = '0;
            endcase
        end

        always_ff @(posedge clk) begin
            raw_q <= raw_d;
            res_q <= red;
        end

        assign res_o[ln*CW +: CW] = res_q;
    end

endmodule : pwo_lane_alu

// File: src/pwo_params_pkg.sv
// Coefficient field constants

package pwo_params_pkg;

    // Width of one coefficient lane
    parameter int unsigned COEF_W = 24;

    // Modulus q of the signature scheme field
    parameter logic [COEF_W-1:0] MOD_Q = 24'd8380417;

    // Unreduced product width
    parameter int unsigned PROD_W = 2 * COEF_W;

endpackage : pwo_params_pkg

// File: src/pwo_sequencer.sv
// Operand read sequencer

module pwo_sequencer #(
    parameter int ADDR_W = 6
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               start_i,
    input  logic               last_write_i,  // From writeback
    output logic               busy_o,
    output logic               op_valid_o,
    output logic [ADDR_W-1:0]  op_addr_o,
    coef_mem_if.reader         rd_a_o,
    coef_mem_if.reader         rd_b_o
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = {ADDR_W{1'b1}};

    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;

    // Start is only taken while idle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_o  <= 1'b0;
            rd_en   <= 1'b0;
            rd_addr <= '0;
        end else begin
            if (start_i && !busy_o) begin
                busy_o  <= 1'b1;
                rd_en   <= 1'b1;
                rd_addr <= '0;
            end else if (rd_en) begin
                if (rd_addr == LAST_ADDR) begin
                    rd_en <= 1'b0;  // All words issued
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
            if (last_write_i) begin
                busy_o <= 1'b0;
            end
        end
    end

    // Same word index read from both operands
    assign rd_a_o.re    = rd_en;
    assign rd_a_o.raddr = rd_addr;
    assign rd_b_o.re    = rd_en;
    assign rd_b_o.raddr = rd_addr;

    // Delayed to line up with rdata
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        op_addr_o <= rd_addr;
    end

endmodule : pwo_sequencer

// File: src/pwo_top.sv
// Pointwise polynomial engine

module pwo_top #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) (
    input  logic                                     clk,
    input  logic                                     arst_n_i,
    input  logic                                     zeroize_i,
    input  pwo_types_pkg::pwo_mode_e                 mode_i,
    input  logic                                     start_i,
    output logic                                     busy_o,
    output logic                                     done_o,
    input  logic                                     load_we_i,
    input  pwo_types_pkg::mem_sel_e                  load_sel_i,
    input  logic [ADDR_W-1:0]                        load_addr_i,
    input  logic [LANES*pwo_params_pkg::COEF_W-1:0]  load_data_i,
    input  logic                                     rd_en_i,
    input  logic [ADDR_W-1:0]                        rd_addr_i,
    output logic [LANES*pwo_params_pkg::COEF_W-1:0]  rd_data_o
);

    coef_mem_if #(.LANES(LANES), .ADDR_W(ADDR_W)) mem_a ();
    coef_mem_if #(.LANES(LANES), .ADDR_W(ADDR_W)) mem_b ();
    coef_mem_if #(.LANES(LANES), .ADDR_W(ADDR_W)) mem_c ();

    logic                                     op_valid;
    logic [ADDR_W-1:0]                        op_addr;
    logic                                     res_valid;
    logic [ADDR_W-1:0]                        res_addr;
    logic [LANES*pwo_params_pkg::COEF_W-1:0]  res_word;
    logic                                     last_write;

    // Host load port onto A or B
    assign mem_a.we    = load_we_i && (load_sel_i == pwo_types_pkg::SEL_A);
    assign mem_a.waddr = load_addr_i;
    assign mem_a.wdata = load_data_i;
    assign mem_b.we    = load_we_i && (load_sel_i == pwo_types_pkg::SEL_B);
    assign mem_b.waddr = load_addr_i;
    assign mem_b.wdata = load_data_i;

    // Host read port on C
    assign mem_c.re    = rd_en_i;
    assign mem_c.raddr = rd_addr_i;
    assign rd_data_o   = mem_c.rdata;

    coef_ram #(.LANES(LANES), .ADDR_W(ADDR_W)) i_mem_a (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .zeroize_i  (zeroize_i),
        .mem_port_i (mem_a.ram)
    );

    coef_ram #(.LANES(LANES), .ADDR_W(ADDR_W)) i_mem_b (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .zeroize_i  (zeroize_i),
        .mem_port_i (mem_b.ram)
    );

    coef_ram #(.LANES(LANES), .ADDR_W(ADDR_W)) i_mem_c (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .zeroize_i  (zeroize_i),
        .mem_port_i (mem_c.ram)
    );

    pwo_sequencer #(.ADDR_W(ADDR_W)) i_sequencer (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .last_write_i (last_write),
        .busy_o       (busy_o),
        .op_valid_o   (op_valid),
        .op_addr_o    (op_addr),
        .rd_a_o       (mem_a.reader),
        .rd_b_o       (mem_b.reader)
    );

    pwo_lane_alu #(.LANES(LANES), .ADDR_W(ADDR_W)) i_lane_alu (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .mode_i      (mode_i),
        .in_valid_i  (op_valid),
        .in_addr_i   (op_addr),
        .opa_i       (mem_a.rdata),
        .opb_i       (mem_b.rdata),
        .res_valid_o (res_valid),
        .res_addr_o  (res_addr),
        .res_o       (res_word)
    );

    pwo_writeback #(.LANES(LANES), .ADDR_W(ADDR_W)) i_writeback (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .res_valid_i  (res_valid),
        .res_addr_i   (res_addr),
        .res_i        (res_word),
        .wr_c_o       (mem_c.writer),
        .last_write_o (last_write),
        .done_o       (done_o)
    );

endmodule : pwo_top

// File: src/pwo_types_pkg.sv
// Engine mode and memory select types

package pwo_types_pkg;

    // Pointwise operation applied to every lane
    typedef enum logic [1:0] {
        MODE_PWM = 2'd0,  // Multiply
        MODE_PWA = 2'd1,  // Add
        MODE_PWS = 2'd2   // Subtract
    } pwo_mode_e;

    // Host load target
    typedef enum logic {
        SEL_A = 1'b0,
        SEL_B = 1'b1
    } mem_sel_e;

endpackage : pwo_types_pkg

// File: src/pwo_writeback.sv
// Result writeback to memory C

module pwo_writeback #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) (
    input  logic                                     clk,
    input  logic                                     arst_n_i,
    input  logic                                     res_valid_i,
    input  logic [ADDR_W-1:0]                        res_addr_i,
    input  logic [LANES*pwo_params_pkg::COEF_W-1:0]  res_i,
    coef_mem_if.writer                               wr_c_o,
    output logic                                     last_write_o,
    output logic                                     done_o
);

    logic at_last;

    assign at_last = res_valid_i && (&res_addr_i);  // Highest word of C

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_c_o.we    <= 1'b0;
            last_write_o <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            wr_c_o.we    <= res_valid_i;
            last_write_o <= at_last;
            done_o       <= last_write_o;  // One cycle after the final write
        end
    end

    // Address and data ride along with the strobe
    always_ff @(posedge clk) begin
        wr_c_o.waddr <= res_addr_i;
        wr_c_o.wdata <= res_i;
    end

endmodule : pwo_writeback

// File: tests/pwo_checker.sv
// Engine protocol assertions

module pwo_checker #(
    parameter int ADDR_W = 6
) (
    input logic clk,
    input logic arst_n_i,
    input logic start_i,
    input logic busy_i,
    input logic done_i,
    input logic load_we_i,
    input logic rd_en_i
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH    = 2 ** ADDR_W;
    localparam int DONE_LAG = DEPTH + 5;  // Done is seen one edge after edge DEPTH+4

    logic start_taken;

    assign start_taken = start_i && !busy_i;

    done_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n_i) done_i |=> !done_i
    ) else $error("done_o stayed high for more than one cycle");

    // Host port stays quiet during a run
    host_idle_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n_i) busy_i |-> !(load_we_i || rd_en_i)
    ) else $error("host load or read issued while busy_o was high");

    done_after_start: assert property (
        @(posedge clk) disable iff (!arst_n_i) $rose(done_i) |-> $past(start_taken, DONE_LAG)
    ) else $error("done_o rose without an accepted start DEPTH+4 cycles before");

endmodule : pwo_checker

bind pwo_top pwo_checker #(.ADDR_W(ADDR_W)) i_checker (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .start_i   (start_i),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .load_we_i (load_we_i),
    .rd_en_i   (rd_en_i)
);

// File: tests/pwo_tb.sv
// Pointwise engine testbench

module pwo_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES      = 4;
    localparam int ADDR_W     = 6;
    localparam int DEPTH      = 2 ** ADDR_W;
    localparam int CW         = pwo_params_pkg::COEF_W;
    localparam int WORD_W     = LANES * CW;
    localparam int N_TESTS    = 5;
    localparam int RST_CYCLES = 16;
    localparam int LIMIT      = RST_CYCLES + N_TESTS * (DEPTH + 2 * DEPTH + 20);

    logic                      clk;
    logic                      arst_n;
    logic                      zeroize;
    pwo_types_pkg::pwo_mode_e  mode;
    logic                      start;
    logic                      busy;
    logic                      done;
    logic                      load_we;
    pwo_types_pkg::mem_sel_e   load_sel;
    logic [ADDR_W-1:0]         load_addr;
    logic [WORD_W-1:0]         load_data;
    logic                      rd_en;
    logic [ADDR_W-1:0]         rd_addr;
    logic [WORD_W-1:0]         rd_data;

    integer            seed;
    string             cur_test;
    int                test_errs;
    int                total_errs;
    int                failed_tests;
    logic              rd_pend;       // Read data valid this cycle
    logic [ADDR_W-1:0] rd_pend_addr;
    logic [WORD_W-1:0] a_words   [DEPTH];
    logic [WORD_W-1:0] b_words   [DEPTH];
    logic [WORD_W-1:0] exp_words [DEPTH];

    pwo_top #(.LANES(LANES), .ADDR_W(ADDR_W)) i_dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .zeroize_i   (zeroize),
        .mode_i      (mode),
        .start_i     (start),
        .busy_o      (busy),
        .done_o      (done),
        .load_we_i   (load_we),
        .load_sel_i  (load_sel),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected lane value straight from the modular rules
    function automatic logic [CW-1:0] ref_lane(input pwo_types_pkg::pwo_mode_e m,
                                               input logic [CW-1:0] a,
                                               input logic [CW-1:0] b);
        logic [63:0] q64;
        logic [63:0] r;
        q64 = 64'(pwo_params_pkg::MOD_Q);
        case (m)
            pwo_types_pkg::MODE_PWM: r = (64'(a) * 64'(b)) % q64;
            pwo_types_pkg::MODE_PWA: r = (64'(a) + 64'(b)) % q64;
            pwo_types_pkg::MODE_PWS: r = (64'(a) + q64 - 64'(b)) % q64;
            default:                 r = '0;
        endcase
        return CW'(r);
    endfunction

    function automatic logic [CW-1:0] rand_coef();
        logic [31:0] r;
        r = $random(seed);
        return CW'(r % 32'(pwo_params_pkg::MOD_Q));  // Always below q
    endfunction

    task automatic compare_value(input string what, input logic [WORD_W-1:0] expected,
                                 input logic [WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0h, actual %0h", what, expected, actual);
            test_errs++;
        end
    endtask

    function automatic void build_expected(input pwo_types_pkg::pwo_mode_e m);
        for (int k = 0; k < DEPTH; k++) begin
            for (int ln = 0; ln < LANES; ln++) begin
                exp_words[k][ln*CW +: CW] = ref_lane(m, a_words[k][ln*CW +: CW],
                                                     b_words[k][ln*CW +: CW]);
            end
        end
    endfunction

    function automatic void end_test();
        if (test_errs == 0) begin
            $display("%s: PASS", cur_test);
        end else begin
            $display("%s: FAIL with %0d errors", cur_test, test_errs);
            failed_tests++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endfunction

    // A words first, then B words, one per cycle
    task automatic load_operands();
        for (int k = 0; k < 2 * DEPTH; k++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= ADDR_W'(k % DEPTH);
            if (k < DEPTH) begin
                load_sel  <= pwo_types_pkg::SEL_A;
                load_data <= a_words[k];
            end else begin
                load_sel  <= pwo_types_pkg::SEL_B;
                load_data <= b_words[k - DEPTH];
            end
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic run_and_wait(input pwo_types_pkg::pwo_mode_e m);
        int n;
        @(posedge clk);
        mode  <= m;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < 2 * DEPTH);
        if (!done) begin
            $display("%s: done_o did not rise within %0d cycles of start", cur_test, n);
            test_errs++;
        end
    endtask

    task automatic read_back_c();
        for (int k = 0; k < DEPTH; k++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= ADDR_W'(k);
        end
        @(posedge clk);
        rd_en <= 1'b0;
        repeat (2) @(negedge clk);  // Let the last word reach the compare
    endtask

    // Compares each read word once its data is valid
    always @(posedge clk) begin
        rd_pend      <= rd_en;
        rd_pend_addr <= rd_addr;
    end

    always @(negedge clk) begin
        if (rd_pend) begin
            compare_value($sformatf("%s word %0d", cur_test, rd_pend_addr),
                          exp_words[rd_pend_addr], rd_data);
        end
    end

    task automatic random_test(input string name, input pwo_types_pkg::pwo_mode_e m);
        cur_test = name;
        for (int k = 0; k < DEPTH; k++) begin
            for (int ln = 0; ln < LANES; ln++) begin
                a_words[k][ln*CW +: CW] = rand_coef();
                b_words[k][ln*CW +: CW] = rand_coef();
            end
        end
        for (int ln = 0; ln < LANES; ln++) begin
            if (m == pwo_types_pkg::MODE_PWA) begin  // q-1 plus q-1
                a_words[0][ln*CW +: CW] = pwo_params_pkg::MOD_Q - 24'd1;
                b_words[0][ln*CW +: CW] = pwo_params_pkg::MOD_Q - 24'd1;
            end
            if (m == pwo_types_pkg::MODE_PWS) begin  // a below b
                a_words[0][ln*CW +: CW] = CW'(ln);
                b_words[0][ln*CW +: CW] = pwo_params_pkg::MOD_Q - 24'd1 - CW'(ln);
            end
        end
        build_expected(m);
        load_operands();
        run_and_wait(m);
        read_back_c();
        end_test();
    endtask

    // Second start lands while busy and must be dropped
    task automatic timing_test();
        int n;
        int done_cnt;
        int first_done;
        int busy_cnt;
        cur_test   = "timing";
        done_cnt   = 0;
        first_done = 0;
        busy_cnt   = 0;
        @(posedge clk);
        start <= 1'b1;
        for (n = 1; n <= DEPTH + 30; n++) begin
            @(posedge clk);
            start <= (n == 10);
            @(negedge clk);
            if (busy) begin
                busy_cnt++;
            end
            if (done) begin
                done_cnt++;
                if (first_done == 0) begin
                    first_done = n;
                end
            end
        end
        compare_value("timing done latency", WORD_W'(DEPTH + 4), WORD_W'(first_done - 1));
        compare_value("timing done pulses", WORD_W'(1), WORD_W'(done_cnt));
        // Busy from the cycle after start up to the cycle done rises
        compare_value("timing busy cycles", WORD_W'(DEPTH + 4), WORD_W'(busy_cnt));
        if (busy) begin
            $display("timing: busy_o was still high after the run ended");
            test_errs++;
        end
        end_test();
    endtask

    task automatic zeroize_test();
        cur_test = "zeroize";
        for (int k = 0; k < DEPTH; k++) begin
            exp_words[k] = '0;
        end
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        read_back_c();
        end_test();
    endtask

    initial begin
        seed         = 32'h56304ca5;
        test_errs    = 0;
        total_errs   = 0;
        failed_tests = 0;
        cur_test     = "reset";
        rd_pend      = 1'b0;
        arst_n       = 1'b0;
        zeroize      = 1'b0;
        mode         = pwo_types_pkg::MODE_PWM;
        start        = 1'b0;
        load_we      = 1'b0;
        load_sel     = pwo_types_pkg::SEL_A;
        load_addr    = '0;
        load_data    = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        random_test("pwm_random", pwo_types_pkg::MODE_PWM);
        random_test("pwa_random", pwo_types_pkg::MODE_PWA);
        random_test("pws_random", pwo_types_pkg::MODE_PWS);
        timing_test();
        zeroize_test();
        $display("Summary: %0d tests, %0d failed, %0d errors", N_TESTS, failed_tests, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Watchdog timeout: the tests did not finish within %0d clock cycles", LIMIT);
        $display("Finished with errors");
        $finish;
    end

endmodule : pwo_tb
